// File: src/blake_pkg.sv
/* types, constants and permutation tables of the 8-round BLAKE-256 mining core
   shared by all RTL modules and by the testbench reference model */
`default_nettype none

package blake_pkg;

   typedef logic [31:0] word_t;

   // working state v0..v15
   typedef struct packed {
      word_t v0, v1, v2, v3;
      word_t v4, v5, v6, v7;
      word_t v8, v9, v10, v11;
      word_t v12, v13, v14, v15;
   } state_t;

   // message block, held pre-xored with the paired constant inside the core
   typedef struct packed {
      word_t m0, m1, m2, m3;
      word_t m4, m5, m6, m7;
      word_t m8, m9, m10, m11;
      word_t m12, m13, m14, m15;
   } msg_t;

   typedef struct packed {
      word_t h0, h1, h2, h3;
      word_t h4, h5, h6, h7;
   } midstate_t;

   // init_nonce sits lowest, so it holds the last 32 bits shifted in
   typedef struct packed {
      word_t w0, w1, w2;
      word_t init_nonce;
   } header_t;

   typedef enum logic [1:0] {
      idle,
      run,
      done
   } ctrl_state_e;

   localparam int num_rounds      = 8;
   localparam int num_half_rounds = 2 * num_rounds;
   localparam int match_bits      = 8;
   localparam int shift_len       = $bits(midstate_t) + $bits(header_t);

   // 640-bit message length
   localparam word_t bit_counter = 32'h0000_0280;

   localparam word_t [0:15] blake_c = {
      32'h243f6a88, 32'h85a308d3, 32'h13198a2e, 32'h03707344,
      32'ha4093822, 32'h299f31d0, 32'h082efa98, 32'hec4e6c89,
      32'h452821e6, 32'h38d01377, 32'hbe5466cf, 32'h34e90c6c,
      32'hc0ac29b7, 32'hc97c50dd, 32'h3f84d5b5, 32'hb5470917
   };

   // one nibble per message index, row r used in round r
   localparam logic [0:num_rounds-1][0:15][3:0] sigma_perm = {
      64'h0123456789abcdef,
      64'hea489fd61c02b753,
      64'hb8c052fdae367194,
      64'h7931dcbe265a40f8,
      64'h905724afe1bc683d,
      64'h2c6a0b834d75fe19,
      64'hc51fed4a0763928b,
      64'hdb7ec13950f4862a
   };

   // m4..m15 of the padded 80-byte header
   localparam word_t [4:15] pad_words = {
      32'h8000_0000, 32'h0, 32'h0, 32'h0,
      32'h0, 32'h0, 32'h0, 32'h0,
      32'h0, 32'h0000_0001, 32'h0, bit_counter
   };

endpackage

`default_nettype wire

// File: src/blake_g_func.sv
/* combinational BLAKE-256 G mixing function, message inputs already xored with constants */
`timescale 1ns/1ps
`default_nettype none

module blake_g_func import blake_pkg::*; (
   input  wire word_t a_i,
   input  wire word_t b_i,
   input  wire word_t c_i,
   input  wire word_t d_i,
   input  wire word_t mc0_i,
   input  wire word_t mc1_i,
   output word_t      a_o,
   output word_t      b_o,
   output word_t      c_o,
   output word_t      d_o
);

   word_t a1, b1, c1, d1;

   function automatic word_t rotr(input word_t x, input int unsigned n);
      return (x >> n) | (x << (32 - n));
   endfunction

   always_comb begin
      a1  = a_i + b_i + mc0_i;
      d1  = rotr(d_i ^ a1, 16);
      c1  = c_i + d1;
      b1  = rotr(b_i ^ c1, 12);
      // second half with the swapped message/constant pair
      a_o = a1 + b1 + mc1_i;
      d_o = rotr(d1 ^ a_o, 8);
      c_o = c1 + d_o;
      b_o = rotr(b1 ^ c_o, 7);
   end

endmodule

`default_nettype wire

// File: src/blake_param_shift.sv
/* serial loader for the midstate and header words, one bit per clock;
   the chain is frozen while a hash is in progress */
`timescale 1ns/1ps
`default_nettype none

module blake_param_shift import blake_pkg::*; (
   input  wire       clk,
   input  wire       rst_n,
   input  wire       shift_i,
   input  wire       din_i,
   input  wire       busy_i,
   output midstate_t midstate_o,
   output header_t   header_o
);

   logic [shift_len-1:0] chain_q;

   // header fills from the lsb, its msb overflows into the midstate
   always_ff @(posedge clk) begin
      if (shift_i && !busy_i) begin
         chain_q <= {chain_q[shift_len-2:0], din_i};
      end
   end

   assign header_o   = chain_q[$bits(header_t)-1:0];
   assign midstate_o = chain_q[shift_len-1:$bits(header_t)];

   // final xor needs the same midstate that seeded the state
   a_frozen_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
      busy_i |=> $stable(midstate_o) && $stable(header_o))
      else $error("parameter chain changed during a hash run");

endmodule

`default_nettype wire

// File: src/blake_round_ctrl.sv
/* start/done sequencer: issues load, then 16 half-round steps, then one done cycle */
`timescale 1ns/1ps
`default_nettype none

module blake_round_ctrl import blake_pkg::*; (
   input  wire        clk,
   input  wire        rst_n,
   input  wire        start_i,
   output logic       load_o,
   output logic       step_o,
   output logic       diag_o,
   output logic [2:0] round_idx_o,
   output logic       busy_o,
   output logic       done_o
);

   ctrl_state_e state_q, state_d;
   logic [3:0]  cnt_q;

   // start is taken in idle or in the done cycle
   assign load_o      = start_i && (state_q != run);
   assign step_o      = (state_q == run);
   assign diag_o      = cnt_q[0];
   assign round_idx_o = cnt_q[3:1];
   assign busy_o      = load_o || step_o;
   assign done_o      = (state_q == done);

   always_comb begin
      state_d = state_q;
      case (state_q)
         idle: if (start_i) state_d = run;
         run:  if (cnt_q == 4'(num_half_rounds - 1)) state_d = done;
         done: state_d = start_i ? run : idle;
         default: state_d = idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= idle;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         if (load_o) begin
            cnt_q <= '0;
         end else if (step_o) begin
            cnt_q <= cnt_q + 4'd1;
         end
      end
   end

   a_done_after_last: assert property (@(posedge clk) disable iff (!rst_n)
      done_o |-> $past(step_o && diag_o && round_idx_o == 3'(num_rounds - 1)));

   a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
      done_o |=> !done_o);

   // a load always restarts at the first column half and never hits a run
   a_load_restart: assert property (@(posedge clk) disable iff (!rst_n)
      load_o |-> !step_o ##1 (step_o && !diag_o && round_idx_o == 3'd0));

endmodule

`default_nettype wire

// File: src/blake_msg_sched.sv
/* message register set, kept xored with the paired constants;
   re-permuted to the next sigma row after every diagonal half-round */
`timescale 1ns/1ps
`default_nettype none

module blake_msg_sched import blake_pkg::*; (
   input  wire        clk,
   input  wire        load_i,
   input  wire        step_i,
   input  wire        diag_i,
   input  wire  [2:0] round_idx_i,
   input  wire header_t header_i,
   input  wire word_t nonce_i,
   output msg_t       msg_o
);

   msg_t         mc_q;
   word_t [0:15] mc_cur;
   word_t [0:15] m_load;
   word_t [0:15] m_cur;
   logic  [2:0]  next_row;

   // slot k carries m[sigma(k)] ^ c[sigma(k^1)], ready for G
   function automatic msg_t mc_row(input word_t [0:15] m, input logic [2:0] r);
      word_t [0:15] mc;
      for (int k = 0; k < 16; k++) begin
         mc[k] = m[sigma_perm[r][k]] ^ blake_c[sigma_perm[r][k ^ 1]];
      end
      return mc;
   endfunction

   assign mc_cur   = mc_q;
   assign next_row = round_idx_i + 3'd1;
   assign msg_o    = mc_q;

   always_comb begin
      m_load[0] = header_i.w0;
      m_load[1] = header_i.w1;
      m_load[2] = header_i.w2;
      m_load[3] = nonce_i;
      for (int i = 4; i < 16; i++) begin
         m_load[i] = pad_words[i];
      end
   end

   // strip the current constants to get the plain message back
   always_comb begin
      m_cur = '0;
      for (int j = 0; j < 16; j++) begin
         m_cur[sigma_perm[round_idx_i][j]] =
            mc_cur[j] ^ blake_c[sigma_perm[round_idx_i][j ^ 1]];
      end
   end

   always_ff @(posedge clk) begin
      if (load_i) begin
         mc_q <= mc_row(m_load, 3'd0);
      end else if (step_i && diag_i) begin
         mc_q <= mc_row(m_cur, next_row);
      end
   end

endmodule

`default_nettype wire

// File: src/blake_round_unit.sv
/* 16-word state register with four G units, one column or diagonal half-round
   per step; seeded from midstate, constants and the bit counter on load */
`timescale 1ns/1ps
`default_nettype none

module blake_round_unit import blake_pkg::*; (
   input  wire            clk,
   input  wire            load_i,
   input  wire            step_i,
   input  wire            diag_i,
   input  wire midstate_t midstate_i,
   input  wire msg_t      msg_i,
   output state_t         state_o
);

   word_t [0:15] v_q;
   word_t [0:15] v_init;
   word_t [0:15] v_next;
   word_t [0:15] mc;
   word_t [0:7]  h;
   logic  [3:0]  pb [4], pc [4], pd [4];
   word_t        ga [4], gb [4], gc [4], gd [4];
   word_t        ra [4], rb [4], rc [4], rd [4];
   word_t        m0 [4], m1 [4];

   assign mc      = msg_i;
   assign h       = midstate_i;
   assign state_o = v_q;

   always_comb begin
      for (int i = 0; i < 8; i++) begin
         v_init[i]     = h[i];
         v_init[8 + i] = blake_c[i];
      end
      // low counter word only, high word is zero
      v_init[12] = blake_c[4] ^ bit_counter;
      v_init[13] = blake_c[5] ^ bit_counter;
   end

   // diagonal shifts rows b, c, d by 1, 2, 3 columns
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         pb[i] = {2'd1, 2'(i) + {1'b0, diag_i}};
         pc[i] = {2'd2, 2'(i) + {diag_i, 1'b0}};
         pd[i] = {2'd3, 2'(i) + {diag_i, diag_i}};
         ga[i] = v_q[i];
         gb[i] = v_q[pb[i]];
         gc[i] = v_q[pc[i]];
         gd[i] = v_q[pd[i]];
         m0[i] = mc[{diag_i, 2'(i), 1'b0}];
         m1[i] = mc[{diag_i, 2'(i), 1'b1}];
      end
   end

   for (genvar gi = 0; gi < 4; gi++) begin : g_unit
      blake_g_func u_g (
         .a_i   (ga[gi]),
         .b_i   (gb[gi]),
         .c_i   (gc[gi]),
         .d_i   (gd[gi]),
         .mc0_i (m0[gi]),
         .mc1_i (m1[gi]),
         .a_o   (ra[gi]),
         .b_o   (rb[gi]),
         .c_o   (rc[gi]),
         .d_o   (rd[gi])
      );
   end

   // results go back where their inputs came from
   always_comb begin
      v_next = v_q;
      for (int i = 0; i < 4; i++) begin
         v_next[i]     = ra[i];
         v_next[pb[i]] = rb[i];
         v_next[pc[i]] = rc[i];
         v_next[pd[i]] = rd[i];
      end
   end

   always_ff @(posedge clk) begin
      if (load_i) begin
         v_q <= v_init;
      end else if (step_i) begin
         v_q <= v_next;
      end
   end

endmodule

`default_nettype wire

// File: src/blake_finalize.sv
/* digest = midstate ^ low state half ^ high state half, plus the difficulty match flag */
`timescale 1ns/1ps
`default_nettype none

module blake_finalize import blake_pkg::*; (
   input  wire midstate_t midstate_i,
   input  wire state_t    state_i,
   input  wire            done_i,
   output midstate_t      digest_o,
   output logic           match_o
);

   word_t [0:7]  h;
   word_t [0:15] v;
   word_t [0:7]  d;

   assign h = midstate_i;
   assign v = state_i;

   always_comb begin
      for (int i = 0; i < 8; i++) begin
         d[i] = h[i] ^ v[i] ^ v[i + 8];
      end
   end

   assign digest_o = d;

   // only meaningful in the done cycle
   assign match_o = done_i && (d[7][match_bits-1:0] == '0);

endmodule

`default_nettype wire

// File: src/blake_core.sv
/* 8-round BLAKE-256 proof-of-work core: serial parameter load, start pulse,
   digest and match valid in the done cycle 17 cycles later */
`timescale 1ns/1ps
`default_nettype none

module blake_core import blake_pkg::*; (
   input  wire        clk,
   input  wire        rst_n,
   input  wire        shift_i,
   input  wire        din_i,
   input  wire        start_i,
   input  wire word_t nonce_i,
   output word_t      init_nonce_o,
   output logic       busy_o,
   output logic       done_o,
   output midstate_t  digest_o,
   output logic       match_o
);

   midstate_t  midstate;
   header_t    header;
   msg_t       msg;
   state_t     state;
   logic       load;
   logic       step;
   logic       diag;
   logic [2:0] round_idx;

   // starting nonce for the external sweep
   assign init_nonce_o = header.init_nonce;

   blake_param_shift u_param_shift (
      .clk        (clk),
      .rst_n      (rst_n),
      .shift_i    (shift_i),
      .din_i      (din_i),
      .busy_i     (busy_o),
      .midstate_o (midstate),
      .header_o   (header)
   );

   blake_round_ctrl u_round_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .start_i     (start_i),
      .load_o      (load),
      .step_o      (step),
      .diag_o      (diag),
      .round_idx_o (round_idx),
      .busy_o      (busy_o),
      .done_o      (done_o)
   );

   blake_msg_sched u_msg_sched (
      .clk         (clk),
      .load_i      (load),
      .step_i      (step),
      .diag_i      (diag),
      .round_idx_i (round_idx),
      .header_i    (header),
      .nonce_i     (nonce_i),
      .msg_o       (msg)
   );

   blake_round_unit u_round_unit (
      .clk        (clk),
      .load_i     (load),
      .step_i     (step),
      .diag_i     (diag),
      .midstate_i (midstate),
      .msg_i      (msg),
      .state_o    (state)
   );

   blake_finalize u_finalize (
      .midstate_i (midstate),
      .state_i    (state),
      .done_i     (done_o),
      .digest_o   (digest_o),
      .match_o    (match_o)
   );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
/* testbench clock with a 20 ns period and an active-low reset held for two cycles */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   // release away from the rising edge
   initial begin
      rst_n_o = 1'b0;
      repeat (2) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: bench/blake_model.svh
/* reference model of 8-round BLAKE-256 on an 80-byte header, for use inside the testbench
   module after the package import */
`ifndef BLAKE_MODEL_SVH
`define BLAKE_MODEL_SVH

function automatic word_t rotate_right(input word_t x, input int n);
   return (x >> n) | (x << (32 - n));
endfunction

// one G step on the message indices x and y of the sigma row
function automatic logic [127:0] g_mix(input word_t a_in, input word_t b_in,
                                       input word_t c_in, input word_t d_in,
                                       input word_t [0:15] m, input int x, input int y);
   word_t a, b, c, d;
   a = a_in + b_in + (m[x] ^ blake_c[y]);
   d = rotate_right(d_in ^ a, 16);
   c = c_in + d;
   b = rotate_right(b_in ^ c, 12);
   a = a + b + (m[y] ^ blake_c[x]);
   d = rotate_right(d ^ a, 8);
   c = c + d;
   b = rotate_right(b ^ c, 7);
   return {a, b, c, d};
endfunction

function automatic midstate_t reference_digest(input midstate_t ms, input header_t hd,
                                               input word_t nonce);
   word_t [0:7]  h;
   word_t [0:15] m;
   word_t [0:15] v;
   word_t [0:7]  dg;
   logic [127:0] r;
   int           col, sh, ia, ib, ic, id;
   h    = ms;
   m    = '0;
   m[0] = hd.w0;
   m[1] = hd.w1;
   m[2] = hd.w2;
   m[3] = nonce;
   // padding of a 640-bit message with end marker, final one bit and length
   m[4]  = 32'h8000_0000;
   m[13] = 32'h0000_0001;
   m[15] = 32'd640;
   for (int i = 0; i < 8; i++) begin
      v[i]     = h[i];
      v[i + 8] = blake_c[i];
   end
   v[12] = v[12] ^ 32'd640;
   v[13] = v[13] ^ 32'd640;
   for (int rnd = 0; rnd < num_rounds; rnd++) begin
      // g 0..3 on the columns and g 4..7 on the diagonals
      for (int g = 0; g < 8; g++) begin
         col = g % 4;
         sh  = g / 4;
         ia  = col;
         ib  = 4 + (col + sh) % 4;
         ic  = 8 + (col + 2 * sh) % 4;
         id  = 12 + (col + 3 * sh) % 4;
         r   = g_mix(v[ia], v[ib], v[ic], v[id], m,
                     sigma_perm[rnd][2 * g], sigma_perm[rnd][2 * g + 1]);
         {v[ia], v[ib], v[ic], v[id]} = r;
      end
   end
   for (int i = 0; i < 8; i++) begin
      dg[i] = h[i] ^ v[i] ^ v[i + 8];
   end
   return dg;
endfunction

`endif

// File: bench/tb_blake_core.sv
/* testbench for the BLAKE-256 mining core with random serial load, hash runs and a nonce
   sweep, all checked by concurrent assertions against the included reference model */
`timescale 1ns/1ps
`default_nettype none

module tb_blake_core import blake_pkg::*; ();

   localparam int max_runs     = 4096;
   localparam int run_cycles   = 20;
   localparam int limit_cycles = (max_runs + 2) * run_cycles + shift_len + 100;
   localparam logic [4:0] done_slot = 5'd17;

   wire                  clk;
   wire                  rst_n;
   logic                 shift_i;
   logic                 din_i;
   logic                 start_i;
   word_t                nonce_i;
   word_t                init_nonce_o;
   logic                 busy_o;
   logic                 done_o;
   midstate_t            digest_o;
   logic                 match_o;

   logic [31:0]          lfsr_q;
   logic [shift_len-1:0] exp_chain;
   int                   shift_count;
   logic [4:0]           exp_cnt;
   logic                 running;
   logic                 exp_busy;
   logic                 exp_match;
   midstate_t            exp_digest;
   logic                 seen_match;
   logic                 seen_miss;
   word_t                sweep;
   int                   runs;

   `include "blake_model.svh"

   tb_clock_gen u_clk (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   blake_core uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .shift_i      (shift_i),
      .din_i        (din_i),
      .start_i      (start_i),
      .nonce_i      (nonce_i),
      .init_nonce_o (init_nonce_o),
      .busy_o       (busy_o),
      .done_o       (done_o),
      .digest_o     (digest_o),
      .match_o      (match_o)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic next_bit();
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      return lfsr_q[0];
   endfunction

   function automatic word_t rand_word();
      word_t w;
      for (int i = 0; i < 32; i++) begin
         w = {w[30:0], next_bit()};
      end
      return w;
   endfunction

   task automatic value_error(input string name, input logic [255:0] got,
                              input logic [255:0] exp);
      $display("Error: time %0t, %s is %0h, expected %0h", $time, name, got, exp);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
   endtask

   task automatic fail_run(input string what);
      $display("%s at time %0t", what, $time);
      $display("Some tests failed");
      $fatal(1, "run aborted");
   endtask

   // 1..16 are the step cycles and 17 is the done cycle
   assign running   = (exp_cnt != 5'd0) && (exp_cnt != done_slot);
   assign exp_busy  = running || start_i;
   assign exp_match = (exp_cnt == done_slot) && (exp_digest.h7[match_bits-1:0] == '0);

   // expected chain contents with shifts ignored while busy
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exp_chain   <= '0;
         shift_count <= 0;
      end else if (shift_i && !exp_busy) begin
         exp_chain   <= {exp_chain[shift_len-2:0], din_i};
         shift_count <= shift_count + 1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exp_cnt <= '0;
      end else if (start_i && !running) begin
         exp_cnt    <= 5'd1;
         exp_digest <= reference_digest(exp_chain[shift_len-1:$bits(header_t)],
                                        exp_chain[$bits(header_t)-1:0], nonce_i);
      end else if (running) begin
         exp_cnt <= exp_cnt + 5'd1;
      end else begin
         exp_cnt <= '0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         seen_match <= 1'b0;
         seen_miss  <= 1'b0;
      end else if (exp_cnt == done_slot) begin
         if (exp_match) begin
            seen_match <= 1'b1;
         end else begin
            seen_miss <= 1'b1;
         end
      end
   end

   a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !busy_o && !done_o && !match_o)
      else fail_run("busy_o, done_o or match_o high during reset");

   a_busy: assert property (@(posedge clk) disable iff (!rst_n)
      busy_o == exp_busy)
      else value_error("busy_o", $sampled(busy_o), $sampled(exp_busy));

   a_done_timing: assert property (@(posedge clk) disable iff (!rst_n)
      done_o == (exp_cnt == done_slot))
      else value_error("done_o", $sampled(done_o), $sampled(exp_cnt == done_slot));

   a_digest: assert property (@(posedge clk) disable iff (!rst_n)
      done_o |-> digest_o == exp_digest)
      else value_error("digest_o", $sampled(digest_o), $sampled(exp_digest));

   a_match: assert property (@(posedge clk) disable iff (!rst_n)
      match_o == exp_match)
      else value_error("match_o", $sampled(match_o), $sampled(exp_match));

   a_nonce_tap: assert property (@(posedge clk) disable iff (!rst_n)
      shift_count >= shift_len |-> init_nonce_o == exp_chain[31:0])
      else value_error("init_nonce_o", $sampled(init_nonce_o), $sampled(exp_chain[31:0]));

   a_nonce_hold: assert property (@(posedge clk) disable iff (!rst_n)
      exp_busy |=> $stable(init_nonce_o))
      else fail_run("init_nonce_o changed during a hash run");

   task automatic load_params();
      for (int i = 0; i < shift_len; i++) begin
         shift_i = 1'b1;
         din_i   = next_bit();
         @(negedge clk);
      end
      shift_i = 1'b0;
   endtask

   // poke adds a start and a shift pulse in the middle of the run
   task automatic hash_run(input word_t nonce, input logic poke);
      int n;
      nonce_i = nonce;
      start_i = 1'b1;
      @(negedge clk);
      start_i = 1'b0;
      if (poke) begin
         repeat (3) @(negedge clk);
         start_i = 1'b1;
         shift_i = 1'b1;
         din_i   = next_bit();
         @(negedge clk);
         start_i = 1'b0;
         shift_i = 1'b0;
      end
      n = 0;
      while (!done_o && n < 2 * run_cycles) begin
         @(negedge clk);
         n++;
      end
      if (!done_o) begin
         fail_run("done_o did not follow start_i");
      end
   endtask

   initial begin
      repeat (limit_cycles) @(posedge clk);
      fail_run("watchdog expired before the tests finished");
   end

   initial begin
      shift_i = 1'b0;
      din_i   = 1'b0;
      start_i = 1'b0;
      nonce_i = '0;
      lfsr_q  = 32'hda60;
      @(posedge rst_n);
      @(negedge clk);
      load_params();
      hash_run(rand_word(), 1'b1);
      hash_run(rand_word(), 1'b0);
      // each run after this one starts in the previous done cycle
      sweep = init_nonce_o;
      runs  = 0;
      while (!(seen_match && seen_miss) && runs < max_runs) begin
         hash_run(sweep, 1'b0);
         sweep = sweep + 32'd1;
         runs++;
      end
      @(negedge clk);
      @(negedge clk);
      if (!(seen_match && seen_miss)) begin
         $display("nonce sweep ended without both a match and a miss");
         $display("Some tests failed");
         $fatal(1, "sweep incomplete");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+bench
src/blake_pkg.sv
src/blake_g_func.sv
src/blake_param_shift.sv
src/blake_round_ctrl.sv
src/blake_msg_sched.sv
src/blake_round_unit.sv
src/blake_finalize.sv
src/blake_core.sv
bench/tb_clock_gen.sv
bench/tb_blake_core.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and fail on the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_blake_core \
   -o tb_blake_core > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_blake_core > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation ended early"; exit 1; }
exit 0
